//--- common/typing_game_params.svh
`ifndef TYPING_GAME_PARAMS_SVH
`define TYPING_GAME_PARAMS_SVH

// Slot bank
`define NUM_SLOTS     4
`define LETTER_COUNT  26
`define START_CODE    27

// Spawn and fall timing, raise for a real display
`define SPAWN_PERIOD  64
`define FALL_SHIFT    2

// Screen geometry
`define FLOOR_Y       600
`define X_MIN         40
`define X_MAX         750
`define LETTER_SIZE   32
`define BANNER_SIZE   64

// Banners
`define START_X       610
`define START_Y       610
`define OVER_X        500
`define OVER_Y        250
`define START_RGB     12'h0CF
`define OVER_RGB      12'hE22

`endif

//--- common/typing_game_pkg.sv
package typing_game_pkg;

    typedef logic [4:0]  key_code_t;
    typedef logic [10:0] coord_t;
    typedef logic [11:0] rgb_t;
    typedef logic [15:0] age_t;
    typedef logic [7:0]  score_t;

    // One falling letter, 40 bits
    typedef struct packed
    {
        logic        active;
        key_code_t   code;
        coord_t      x;
        coord_t      y;
        logic [11:0] age;
    } slot_t;

    typedef enum logic [1:0]
    {
        IDLE = 2'd0,
        RUN  = 2'd1,
        OVER = 2'd2
    } game_state_t;

    //////////////////////////////
    // Letter colour
    //////////////////////////////

    // Full red, green from the low code bits, top code bit in blue
    function automatic rgb_t letter_rgb(input key_code_t code);
        rgb_t colour;
        colour[11:8] = 4'hF;
        colour[7:4]  = code[3:0];
        colour[3:1]  = 3'b000;
        colour[0]    = code[4];
        return colour;
    endfunction

endpackage

//--- common/field_if.sv
`timescale 1ns/1ns
`include "typing_game_params.svh"

interface field_if import typing_game_pkg::*; ();

    slot_t [`NUM_SLOTS-1:0] slots;
    logic                   floor_hit;
    logic                   hit;
    game_state_t            state;
    logic                   restart;

    modport field
    (
        output slots, floor_hit, hit,
        input  state, restart
    );

    modport ctrl
    (
        output state, restart,
        input  floor_hit, hit
    );

    modport mixer
    (
        input slots, state
    );

endinterface

//--- letter_field/letter_field.sv
`timescale 1ns/1ns
`include "typing_game_params.svh"

module letter_field import typing_game_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n,
    input  logic      key_valid,
    input  key_code_t key_code,
    field_if.field    fld
);

    localparam int SPAWN_W = $clog2(`SPAWN_PERIOD);

    logic                  running;
    logic                  key_valid_q;
    key_code_t             key_q;
    logic                  letter_key;
    key_code_t             letter_cnt;
    coord_t                col_cnt;
    logic [SPAWN_W-1:0]    spawn_cnt;
    logic                  spawn_due;
    logic [`NUM_SLOTS-1:0] spawn_sel;
    logic [`NUM_SLOTS-1:0] clear_sel;

    // Quadratic fall law
    function automatic coord_t fall_height(input logic [11:0] age);
        age_t base;
        age_t square;
        base   = age_t'(age) >> `FALL_SHIFT;
        square = base * base;
        return coord_t'(square);
    endfunction

    assign running    = (fld.state == RUN);
    assign spawn_due  = (spawn_cnt == SPAWN_W'(`SPAWN_PERIOD - 1));
    assign letter_key = key_valid_q && (key_q >= 5'd1) && (key_q <= 5'(`LETTER_COUNT));

    // Keys act one cycle after they are sampled
    always_ff @(posedge clk)
    begin
        key_q <= key_code;
    end

    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            key_valid_q <= 1'b0;
            fld.hit     <= 1'b0;
        end
        else
        begin
            key_valid_q <= key_valid;
            fld.hit     <= running && letter_key && (|clear_sel) && !fld.restart;
        end
    end

    //////////////////////////////
    // Run counters
    //////////////////////////////

    always_ff @(posedge clk)
    begin
        if (!rst_n || fld.restart)
        begin
            letter_cnt <= 5'd1;
            col_cnt    <= coord_t'(`X_MIN);
            spawn_cnt  <= '0;
        end
        else if (running)
        begin
            if (letter_cnt == 5'(`LETTER_COUNT))
                letter_cnt <= 5'd1;
            else
                letter_cnt <= letter_cnt + 5'd1;

            if (col_cnt == coord_t'(`X_MAX))
                col_cnt <= coord_t'(`X_MIN);
            else
                col_cnt <= col_cnt + 11'd1;

            if (spawn_due)
                spawn_cnt <= '0;
            else
                spawn_cnt <= spawn_cnt + SPAWN_W'(1);
        end
    end

    //////////////////////////////
    // Slot bank
    //////////////////////////////

    // Lowest free slot and lowest matching slot as one-hot masks
    always_comb
    begin
        spawn_sel = '0;
        clear_sel = '0;
        for (int i = `NUM_SLOTS - 1; i >= 0; i--)
        begin
            if (!fld.slots[i].active)
            begin
                spawn_sel    = '0;
                spawn_sel[i] = 1'b1;
            end
            if (fld.slots[i].active && (fld.slots[i].code == key_q))
            begin
                clear_sel    = '0;
                clear_sel[i] = 1'b1;
            end
        end
    end

    always_comb
    begin
        fld.floor_hit = 1'b0;
        for (int i = 0; i < `NUM_SLOTS; i++)
        begin
            if (fld.slots[i].active && (fld.slots[i].y >= coord_t'(`FLOOR_Y)))
                fld.floor_hit = 1'b1;
        end
    end

    // Slots freeze outside RUN
    always_ff @(posedge clk)
    begin
        for (int i = 0; i < `NUM_SLOTS; i++)
        begin
            if (!rst_n || fld.restart)
                fld.slots[i] <= '0;
            else if (running)
            begin
                if (letter_key && clear_sel[i])
                    fld.slots[i].active <= 1'b0;
                else if (spawn_due && spawn_sel[i])
                    fld.slots[i] <= '{active: 1'b1, code: letter_cnt, x: col_cnt,
                                      y: '0, age: '0};
                else if (fld.slots[i].active)
                begin
                    fld.slots[i].age <= fld.slots[i].age + 12'd1;
                    fld.slots[i].y   <= fall_height(fld.slots[i].age);
                end
            end
        end
    end

    // Letter counter wrap must never spawn a bad code
    for (genvar g = 0; g < `NUM_SLOTS; g++)
    begin : g_code_chk
        a_code_range: assert property (@(posedge clk) disable iff (!rst_n)
            fld.slots[g].active |->
                (fld.slots[g].code >= 5'd1) && (fld.slots[g].code <= 5'(`LETTER_COUNT)));
    end

    // A hit may still land on the edge that ends the round
    a_hit_in_run: assert property (@(posedge clk) disable iff (!rst_n)
        fld.hit |-> ((fld.state == RUN) || $rose(fld.state == OVER)));

endmodule

//--- design/game_ctrl.sv
`timescale 1ns/1ns
`include "typing_game_params.svh"

module game_ctrl import typing_game_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n,
    input  logic      key_valid,
    input  key_code_t key_code,
    field_if.ctrl     ctl,
    output score_t    score
);

    logic        start_key;
    game_state_t state_next;

    // Start is accepted in every state
    assign start_key = key_valid && (key_code == 5'(`START_CODE));

    //////////////////////////////
    // Round FSM
    //////////////////////////////

    always_comb
    begin
        state_next = ctl.state;
        if (ctl.restart)
            state_next = RUN;
        else
        begin
            case (ctl.state)
                IDLE:    state_next = IDLE;
                RUN:     state_next = ctl.floor_hit ? OVER : RUN;
                OVER:    state_next = OVER;
                default: state_next = IDLE;
            endcase
        end
    end

    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            ctl.state   <= IDLE;
            ctl.restart <= 1'b0;
        end
        else
        begin
            ctl.state   <= state_next;
            ctl.restart <= start_key;
        end
    end

    // Saturating hit counter
    always_ff @(posedge clk)
    begin
        if (!rst_n || ctl.restart)
            score <= '0;
        else if (ctl.hit && (score != '1))
            score <= score + 8'd1;
    end

    // A new round starts running with the field clear of the floor
    a_no_restart_over: assert property (@(posedge clk) disable iff (!rst_n)
        ctl.restart |=> (ctl.state == RUN) && !ctl.floor_hit);

endmodule

//--- design/pixel_mixer.sv
`timescale 1ns/1ns
`include "typing_game_params.svh"

module pixel_mixer import typing_game_pkg::*;
(
    input  logic   clk,
    input  logic   rst_n,
    input  coord_t hcount,
    input  coord_t vcount,
    field_if.mixer mix,
    output rgb_t   rgb
);

    rgb_t pixel;

    // Corner inclusive, far edge exclusive
    function automatic logic in_box(
        input coord_t      px,
        input coord_t      py,
        input coord_t      bx,
        input coord_t      by,
        input logic [11:0] size
    );
        logic [11:0] x_end;
        logic [11:0] y_end;
        x_end = {1'b0, bx} + size;
        y_end = {1'b0, by} + size;
        return (px >= bx) && ({1'b0, px} < x_end) && (py >= by) && ({1'b0, py} < y_end);
    endfunction

    //////////////////////////////
    // Layers
    //////////////////////////////

    always_comb
    begin
        pixel = '0;

        // Walk down so the lowest slot lands on top
        for (int i = `NUM_SLOTS - 1; i >= 0; i--)
        begin
            if (mix.slots[i].active &&
                in_box(hcount, vcount, mix.slots[i].x, mix.slots[i].y, 12'(`LETTER_SIZE)))
                pixel = letter_rgb(mix.slots[i].code);
        end

        if ((mix.state == IDLE) &&
            in_box(hcount, vcount, coord_t'(`START_X), coord_t'(`START_Y),
                   12'(`BANNER_SIZE)))
            pixel = `START_RGB;
        else if ((mix.state == OVER) &&
                 in_box(hcount, vcount, coord_t'(`OVER_X), coord_t'(`OVER_Y),
                        12'(`BANNER_SIZE)))
            pixel = `OVER_RGB;
    end

    always_ff @(posedge clk)
    begin
        if (!rst_n)
            rgb <= '0;
        else
            rgb <= pixel;
    end

endmodule

//--- design/typing_game_top.sv
`timescale 1ns/1ns

module typing_game_top import typing_game_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n,
    input  logic      key_valid,
    input  key_code_t key_code,
    input  coord_t    hcount,
    input  coord_t    vcount,
    output rgb_t      rgb,
    output logic      game_over,
    output score_t    score
);

    field_if fld ();

    letter_field letter_field_i
    (
        .clk       (clk),
        .rst_n     (rst_n),
        .key_valid (key_valid),
        .key_code  (key_code),
        .fld       (fld.field)
    );

    game_ctrl game_ctrl_i
    (
        .clk       (clk),
        .rst_n     (rst_n),
        .key_valid (key_valid),
        .key_code  (key_code),
        .ctl       (fld.ctrl),
        .score     (score)
    );

    pixel_mixer pixel_mixer_i
    (
        .clk       (clk),
        .rst_n     (rst_n),
        .hcount    (hcount),
        .vcount    (vcount),
        .mix       (fld.mixer),
        .rgb       (rgb)
    );

    assign game_over = (fld.state == OVER);

endmodule

//--- dv/typing_game_tests.svh
`ifndef TYPING_GAME_TESTS_SVH
`define TYPING_GAME_TESTS_SVH

// Box centre of spawn n, frozen once the round is over
task automatic check_letter_box(input int n, input int c, input logic present);
    int   c_eff;
    int   h;
    int   v;
    rgb_t expected;
    rgb_t value;
    goto_run_cycle(c);
    c_eff    = (c > freeze_cycle) ? freeze_cycle : c;
    h        = spawn_column(n) + `LETTER_SIZE / 2;
    v        = letter_height(n, c_eff) + `LETTER_SIZE / 2;
    expected = present ? expected_colour(spawn_letter(n)) : rgb_t'(0);
    probe_pixel(h, v, value);
    check_rgb($sformatf("rgb at (%0d,%0d)", h, v), expected, value);
endtask

task automatic check_first_spawn();
    check_pixel(`START_X + 5, `START_Y + 5, rgb_t'(0));
    check_letter_box(0, spawn_cycle(0), 1'b0);
    check_letter_box(0, spawn_cycle(0) + 2, 1'b1);
endtask

task automatic test_after_reset();
    @(negedge clk);
    check_score("score", 8'd0, score);
    check_flag("game_over", 1'b0, game_over);
    check_pixel(`START_X + 5, `START_Y + 5, `START_RGB);
    check_pixel(`START_X + `BANNER_SIZE - 1, `START_Y + `BANNER_SIZE - 1, `START_RGB);
    check_pixel(`START_X - 1, `START_Y + 5, rgb_t'(0));
    check_pixel(`START_X + `BANNER_SIZE, `START_Y + 5, rgb_t'(0));
endtask

task automatic test_first_spawn();
    start_round();
    check_first_spawn();
endtask

task automatic test_letter_hit();
    press_key(spawn_letter(0));
    wait_score(8'd1, 3);
    check_letter_box(0, spawn_cycle(0) + 20, 1'b0);
endtask

task automatic test_wrong_keys();
    key_code_t   held;
    key_code_t   code;
    logic [31:0] r;
    held = spawn_letter(1);
    check_letter_box(1, spawn_cycle(1) + 2, 1'b1);
    // Letters other than the one on screen
    for (int i = 0; i < 8; i++)
    begin
        r    = next_random() % 32'd25;
        code = key_code_t'(r + 32'd1);
        if (code >= held)
            code = code + 5'd1;
        press_key(code);
        settle(3);
        check_score("score", 8'd1, score);
    end
    check_letter_box(1, spawn_cycle(1) + 50, 1'b1);
endtask

task automatic test_game_over();
    int floor_c;
    // Spawn 1 is the oldest letter still falling
    floor_c = spawn_cycle(1) + 1 + floor_age();
    goto_run_cycle(floor_c);
    @(negedge clk);
    check_flag("game_over", 1'b0, game_over);
    @(negedge clk);
    check_flag("game_over", 1'b1, game_over);
    freeze_cycle = floor_c + 1;
    check_pixel(`OVER_X + 5, `OVER_Y + 5, `OVER_RGB);
    press_key(spawn_letter(2));
    settle(3);
    check_score("score", 8'd1, score);
    check_flag("game_over", 1'b1, game_over);
    check_letter_box(2, floor_c + 30, 1'b1);
    check_letter_box(1, floor_c + 40, 1'b1);
endtask

task automatic test_restart();
    start_round();
    wait_game_over(1'b0, 3);
    wait_score(8'd0, 3);
    check_pixel(`OVER_X + 5, `OVER_Y + 5, rgb_t'(0));
    check_first_spawn();
endtask

`endif

//--- dv/typing_game_tb.sv
`timescale 1ns/1ns
`include "typing_game_params.svh"

module typing_game_tb import typing_game_pkg::*;
();

    localparam int NO_FREEZE = 2147483647;

    logic      clk;
    logic      rst_n;
    logic      key_valid;
    key_code_t key_code;
    coord_t    hcount;
    coord_t    vcount;
    rgb_t      rgb;
    logic      game_over;
    score_t    score;

    // Edge index, read right after a rising edge
    int          cycle = 0;
    int          key_edge;
    int          run_start;
    int          freeze_cycle;
    logic [31:0] rng_state;

    typing_game_top typing_game_top_i
    (
        .clk       (clk),
        .rst_n     (rst_n),
        .key_valid (key_valid),
        .key_code  (key_code),
        .hcount    (hcount),
        .vcount    (vcount),
        .rgb       (rgb),
        .game_over (game_over),
        .score     (score)
    );

    initial
    begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    always @(posedge clk)
        cycle <= cycle + 1;

    //////////////////////////////
    // Reference model
    //////////////////////////////

    function automatic int spawn_cycle(input int n);
        return (n + 1) * `SPAWN_PERIOD - 1;
    endfunction

    function automatic key_code_t spawn_letter(input int n);
        return key_code_t'((spawn_cycle(n) % `LETTER_COUNT) + 1);
    endfunction

    function automatic int spawn_column(input int n);
        return `X_MIN + (spawn_cycle(n) % (`X_MAX - `X_MIN + 1));
    endfunction

    // k run edges after the slot became visible
    function automatic int height_at_age(input int k);
        int base;
        if (k <= 0)
            return 0;
        base = (k - 1) >> `FALL_SHIFT;
        return base * base;
    endfunction

    function automatic int letter_height(input int n, input int c);
        return height_at_age(c - (spawn_cycle(n) + 1));
    endfunction

    function automatic int floor_age();
        int k;
        k = 1;
        while (height_at_age(k) < `FLOOR_Y)
            k++;
        return k;
    endfunction

    function automatic rgb_t expected_colour(input key_code_t code);
        return {4'hF, code[3:0], 3'b000, code[4]};
    endfunction

    function automatic logic [31:0] next_random();
        logic [31:0] x;
        x = rng_state;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        rng_state = x;
        return x;
    endfunction

    //////////////////////////////
    // Checks
    //////////////////////////////

    task automatic stop_on_failure();
        $display("Result: FAILED");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic check_rgb(input string name, input rgb_t expected, input rgb_t actual);
        if (actual !== expected)
        begin
            $display("CHECK FAILED at time %0t: %s expected %h, got %h",
                     $time, name, expected, actual);
            stop_on_failure();
        end
    endtask

    task automatic check_score(input string name, input score_t expected,
                               input score_t actual);
        if (actual !== expected)
        begin
            $display("CHECK FAILED at time %0t: %s expected %0d, got %0d",
                     $time, name, expected, actual);
            stop_on_failure();
        end
    endtask

    task automatic check_flag(input string name, input logic expected, input logic actual);
        if (actual !== expected)
        begin
            $display("CHECK FAILED at time %0t: %s expected %b, got %b",
                     $time, name, expected, actual);
            stop_on_failure();
        end
    endtask

    //////////////////////////////
    // Drive and wait
    //////////////////////////////

    task automatic press_key(input key_code_t code);
        @(posedge clk);
        key_valid <= 1'b1;
        key_code  <= code;
        key_edge  = cycle;
        @(posedge clk);
        key_valid <= 1'b0;
    endtask

    // Call right after a rising edge
    task automatic probe_pixel(input int h, input int v, output rgb_t value);
        hcount <= coord_t'(h);
        vcount <= coord_t'(v);
        @(posedge clk);
        @(negedge clk);
        value = rgb;
    endtask

    task automatic check_pixel(input int h, input int v, input rgb_t expected);
        rgb_t value;
        @(posedge clk);
        probe_pixel(h, v, value);
        check_rgb($sformatf("rgb at (%0d,%0d)", h, v), expected, value);
    endtask

    task automatic goto_run_cycle(input int c);
        int guard;
        guard = 0;
        @(posedge clk);
        while ((cycle - run_start) < c)
        begin
            guard++;
            if (guard > 2000)
            begin
                $display("Timed out waiting for run cycle %0d", c);
                stop_on_failure();
            end
            @(posedge clk);
        end
        if ((cycle - run_start) != c)
        begin
            $display("Run cycle %0d had already passed when the test asked for it", c);
            stop_on_failure();
        end
    endtask

    task automatic wait_score(input score_t expected, input int limit);
        int n;
        n = 0;
        @(negedge clk);
        while (score !== expected)
        begin
            n++;
            if (n >= limit)
            begin
                $display("Timed out after %0d cycles waiting for score %0d, still %0d",
                         limit, expected, score);
                stop_on_failure();
            end
            @(negedge clk);
        end
    endtask

    task automatic wait_game_over(input logic expected, input int limit);
        int n;
        n = 0;
        @(negedge clk);
        while (game_over !== expected)
        begin
            n++;
            if (n >= limit)
            begin
                $display("Timed out after %0d cycles waiting for game_over to be %b",
                         limit, expected);
                stop_on_failure();
            end
            @(negedge clk);
        end
    endtask

    task automatic settle(input int cycles);
        for (int i = 0; i < cycles; i++)
            @(negedge clk);
    endtask

    task automatic start_round();
        press_key(key_code_t'(`START_CODE));
        run_start    = key_edge + 2;
        freeze_cycle = NO_FREEZE;
    endtask

    `include "typing_game_tests.svh"

    initial
    begin
        rst_n        <= 1'b0;
        key_valid    <= 1'b0;
        key_code     <= '0;
        hcount       <= '0;
        vcount       <= '0;
        run_start    = 0;
        freeze_cycle = NO_FREEZE;
        rng_state    = 32'hac40;
        repeat (5) @(posedge clk);
        rst_n <= 1'b1;

        test_after_reset();
        test_first_spawn();
        test_letter_hit();
        test_wrong_keys();
        test_game_over();
        test_restart();

        $display("Result: PASSED");
        $finish;
    end

endmodule

//--- compile.f
+incdir+common
+incdir+dv
common/typing_game_pkg.sv
common/field_if.sv
letter_field/letter_field.sv
design/game_ctrl.sv
design/pixel_mixer.sv
design/typing_game_top.sv
dv/typing_game_tb.sv

//--- Makefile
TOOL     = verilator
FLAGS    = --binary --timing --assert -sv
TOP      = typing_game_tb
FILELIST = compile.f
OBJ_DIR  = obj_dir
PASS_MSG = Result: PASSED

.PHONY: all compile run clean

all: run

compile:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

# Status comes from the search for the pass line
run: compile
	@out=$$(./$(OBJ_DIR)/V$(TOP)); echo "$$out"; echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
